// ==== hw/bmd_csr_pkg.sv ====
/*
 * Shared definitions of the DMA endpoint CSR block
 *  - Register word map and general-purpose bank range
 *  - Identification fields of register 0
 *  - Descriptor, control and command layouts
 *  - Register word union and general-purpose bank type
 */
package bmd_csr_pkg;

   // ----------------------------------------
   // Register map
   // ----------------------------------------
   localparam int CSR_ADDR_W = 7;
   typedef logic [CSR_ADDR_W-1:0] csr_addr_t;

   localparam csr_addr_t REG_ID_CTRL   = 7'd0;
   localparam csr_addr_t REG_DMA_CTRL  = 7'd1;
   localparam csr_addr_t REG_MWR_ADDR  = 7'd2;
   localparam csr_addr_t REG_MWR_DESC  = 7'd3;
   localparam csr_addr_t REG_MWR_COUNT = 7'd4;
   localparam csr_addr_t REG_MWR_DATA  = 7'd5;
   localparam csr_addr_t REG_CPLD_DATA = 7'd6;
   localparam csr_addr_t REG_MRD_ADDR  = 7'd7;
   localparam csr_addr_t REG_MRD_DESC  = 7'd8;
   localparam csr_addr_t REG_MRD_COUNT = 7'd9;
   localparam csr_addr_t REG_MWR_PERF  = 7'd10;
   localparam csr_addr_t REG_MRD_PERF  = 7'd11;
   localparam csr_addr_t REG_CPLD_SIZE = 7'd14;
   localparam csr_addr_t GP_BASE       = 7'd25;  // First general-purpose word

   localparam int GP_COUNT = 4;
   localparam int GP_IDX_W = $clog2(GP_COUNT);

   // Identification word fields
   localparam logic [7:0] FPGA_FAMILY    = 8'h14;
   localparam logic [3:0] INTERFACE_TYPE = 4'h1;
   localparam logic [7:0] VERSION_NUMBER = 8'h16;

   localparam int CPLD_SIZE_W = 21;  // Completion size compare width

   // ----------------------------------------
   // Register layouts
   // ----------------------------------------
   typedef struct packed {
      logic [7:0]  up_addr;         // Upper address bits for 64-bit TLPs
      logic [1:0]  rsvd;
      logic        zerolen_en;
      logic        phant_func_dis;
      logic        en_64b;
      logic [2:0]  tlp_tc;
      logic [15:0] len;             // Length in dwords
   } dma_desc_t;

   // One engine's byte of the control register
   typedef struct packed {
      logic       int_dis;
      logic       nosnoop;
      logic       relaxed_order;
      logic [3:0] rsvd;
      logic       start;
   } dma_eng_bits_t;

   typedef struct packed {
      logic [6:0]    rsvd_hi;
      logic          rd_done;
      dma_eng_bits_t rd;
      logic [6:0]    rsvd_mid;
      logic          wr_done;
      dma_eng_bits_t wr;
   } dma_ctrl_t;

   typedef union packed {
      logic [31:0] raw;
      dma_desc_t   desc;
      dma_ctrl_t   ctrl;
   } csr_word_u;

   typedef struct packed {
      logic        start;
      logic        int_dis;
      logic        relaxed_order;
      logic        nosnoop;
      logic [31:0] addr;
      dma_desc_t   desc;
      logic [15:0] count;
   } dma_cmd_t;

   typedef logic [GP_COUNT-1:0][31:0] gp_bank_t;

endpackage

// ==== hw/csr_regfile.sv ====
/*
 * DMA control and status register file
 *  - Write decode of registers 0 to 9
 *  - Registered read multiplexer, merged with the bank read word
 *  - Combined initiator reset and start-bit hold
 */
`timescale 1ns/100ps

module csr_regfile (
   input  logic                    clk,
   input  logic                    init_rst_i,
   input  bmd_csr_pkg::csr_addr_t  a_i,
   input  logic                    wr_en_i,
   input  bmd_csr_pkg::csr_word_u  wr_d_i,
   input  logic                    mwr_done_i,
   input  logic                    mrd_done_i,
   input  logic [31:0]             mwr_perf_i,
   input  logic [31:0]             mrd_perf_i,
   input  logic [31:0]             cpld_data_size_i,
   input  logic [31:0]             gp_rd_d_i,
   output bmd_csr_pkg::csr_word_u  rd_d_o,
   output logic                    init_rst_o,
   output bmd_csr_pkg::dma_cmd_t   mwr_cmd_o,
   output bmd_csr_pkg::dma_cmd_t   mrd_cmd_o,
   output logic [31:0]             mwr_data_o,
   output logic [31:0]             cpld_data_o
);

   logic                   sw_rst_q;    // Software initiator reset, reg 0 bit 0
   logic                   start_hold;
   bmd_csr_pkg::dma_ctrl_t ctrl_rd;
   bmd_csr_pkg::csr_word_u rd_q;

   // Keeps the implemented descriptor fields
   function automatic bmd_csr_pkg::dma_desc_t keep_desc(
      input bmd_csr_pkg::dma_desc_t d,
      input logic                   keep_zerolen
   );
      bmd_csr_pkg::dma_desc_t k;
      k            = d;
      k.rsvd       = 2'b00;
      k.zerolen_en = d.zerolen_en & keep_zerolen;
      return k;
   endfunction

   // ----------------------------------------
   // Initiator reset
   // ----------------------------------------
   always_ff @(posedge clk) begin
      init_rst_o <= init_rst_i | sw_rst_q;
   end

   assign start_hold = sw_rst_q | init_rst_o;

   // ----------------------------------------
   // Write decode
   // ----------------------------------------
   always_ff @(posedge clk) begin
      if (init_rst_i) begin
         sw_rst_q    <= 1'b0;
         mwr_cmd_o   <= '0;
         mrd_cmd_o   <= '0;
         mwr_data_o  <= '0;
         cpld_data_o <= '0;
      end else begin
         if (wr_en_i) begin
            case (a_i)
               bmd_csr_pkg::REG_ID_CTRL: sw_rst_q <= wr_d_i.raw[0];
               bmd_csr_pkg::REG_DMA_CTRL: begin
                  mwr_cmd_o.start         <= wr_d_i.ctrl.wr.start;
                  mwr_cmd_o.relaxed_order <= wr_d_i.ctrl.wr.relaxed_order;
                  mwr_cmd_o.nosnoop       <= wr_d_i.ctrl.wr.nosnoop;
                  mwr_cmd_o.int_dis       <= wr_d_i.ctrl.wr.int_dis;
                  mrd_cmd_o.start         <= wr_d_i.ctrl.rd.start;
                  mrd_cmd_o.relaxed_order <= wr_d_i.ctrl.rd.relaxed_order;
                  mrd_cmd_o.nosnoop       <= wr_d_i.ctrl.rd.nosnoop;
                  mrd_cmd_o.int_dis       <= wr_d_i.ctrl.rd.int_dis;
               end
               bmd_csr_pkg::REG_MWR_ADDR:  mwr_cmd_o.addr  <= wr_d_i.raw;
               bmd_csr_pkg::REG_MWR_DESC:  mwr_cmd_o.desc  <= keep_desc(wr_d_i.desc, 1'b1);
               bmd_csr_pkg::REG_MWR_COUNT: mwr_cmd_o.count <= wr_d_i.raw[15:0];
               bmd_csr_pkg::REG_MWR_DATA:  mwr_data_o      <= wr_d_i.raw;
               bmd_csr_pkg::REG_CPLD_DATA: cpld_data_o     <= wr_d_i.raw;
               bmd_csr_pkg::REG_MRD_ADDR:  mrd_cmd_o.addr  <= wr_d_i.raw;
               bmd_csr_pkg::REG_MRD_DESC:  mrd_cmd_o.desc  <= keep_desc(wr_d_i.desc, 1'b0);
               bmd_csr_pkg::REG_MRD_COUNT: mrd_cmd_o.count <= wr_d_i.raw[15:0];
               default: ;
            endcase
         end

         // Engines stay idle during initiator reset, overriding a start write
         if (start_hold) begin
            mwr_cmd_o.start <= 1'b0;
            mrd_cmd_o.start <= 1'b0;
         end
      end
   end

   // ----------------------------------------
   // Read path
   // ----------------------------------------
   always_comb begin
      ctrl_rd                  = '0;
      ctrl_rd.wr.start         = mwr_cmd_o.start;
      ctrl_rd.wr.relaxed_order = mwr_cmd_o.relaxed_order;
      ctrl_rd.wr.nosnoop       = mwr_cmd_o.nosnoop;
      ctrl_rd.wr.int_dis       = mwr_cmd_o.int_dis;
      ctrl_rd.wr_done          = mwr_done_i;
      ctrl_rd.rd.start         = mrd_cmd_o.start;
      ctrl_rd.rd.relaxed_order = mrd_cmd_o.relaxed_order;
      ctrl_rd.rd.nosnoop       = mrd_cmd_o.nosnoop;
      ctrl_rd.rd.int_dis       = mrd_cmd_o.int_dis;
      ctrl_rd.rd_done          = mrd_done_i;
   end

   always_ff @(posedge clk) begin
      case (a_i)
         bmd_csr_pkg::REG_ID_CTRL: begin
            rd_q.raw <= {bmd_csr_pkg::FPGA_FAMILY, 4'h0, bmd_csr_pkg::INTERFACE_TYPE,
                         bmd_csr_pkg::VERSION_NUMBER, 7'h00, sw_rst_q};
         end
         bmd_csr_pkg::REG_DMA_CTRL:  rd_q.ctrl <= ctrl_rd;
         bmd_csr_pkg::REG_MWR_ADDR:  rd_q.raw  <= mwr_cmd_o.addr;
         bmd_csr_pkg::REG_MWR_DESC:  rd_q.desc <= mwr_cmd_o.desc;
         bmd_csr_pkg::REG_MWR_COUNT: rd_q.raw  <= {16'h0000, mwr_cmd_o.count};
         bmd_csr_pkg::REG_MWR_DATA:  rd_q.raw  <= mwr_data_o;
         bmd_csr_pkg::REG_CPLD_DATA: rd_q.raw  <= cpld_data_o;
         bmd_csr_pkg::REG_MRD_ADDR:  rd_q.raw  <= mrd_cmd_o.addr;
         bmd_csr_pkg::REG_MRD_DESC:  rd_q.desc <= mrd_cmd_o.desc;
         bmd_csr_pkg::REG_MRD_COUNT: rd_q.raw  <= {16'h0000, mrd_cmd_o.count};
         bmd_csr_pkg::REG_MWR_PERF:  rd_q.raw  <= mwr_perf_i;
         bmd_csr_pkg::REG_MRD_PERF:  rd_q.raw  <= mrd_perf_i;
         bmd_csr_pkg::REG_CPLD_SIZE: rd_q.raw  <= cpld_data_size_i;
         default:                    rd_q.raw  <= '0;  // Includes the bank range
      endcase
   end

   // Bank word is zero outside its own range
   assign rd_d_o.raw = rd_q.raw | gp_rd_d_i;

endmodule

// ==== hw/gp_port_bank.sv ====
/*
 * General-purpose register bank
 *  - Downstream words written by the host
 *  - Registered upstream word read selection
 */
`timescale 1ns/100ps

module gp_port_bank (
   input  logic                    clk,
   input  logic                    init_rst_i,
   input  bmd_csr_pkg::csr_addr_t  a_i,
   input  logic                    wr_en_i,
   input  bmd_csr_pkg::csr_word_u  wr_d_i,
   input  bmd_csr_pkg::gp_bank_t   gp_up_i,
   output bmd_csr_pkg::gp_bank_t   gp_dn_o,
   output logic [31:0]             gp_rd_d_o
);

   logic [bmd_csr_pkg::CSR_ADDR_W-1:0] gp_off;   // Wraps high below GP_BASE
   logic [bmd_csr_pkg::GP_IDX_W-1:0]   gp_idx;
   logic                               in_range;

   assign gp_off   = a_i - bmd_csr_pkg::GP_BASE;
   assign gp_idx   = gp_off[bmd_csr_pkg::GP_IDX_W-1:0];
   assign in_range = (gp_off < bmd_csr_pkg::GP_COUNT);

   // Downstream words
   always_ff @(posedge clk) begin
      if (init_rst_i) begin
         gp_dn_o <= '0;
      end else if (wr_en_i && in_range) begin
         gp_dn_o[gp_idx] <= wr_d_i.raw;
      end
   end

   // Upstream read, zero outside the bank
   always_ff @(posedge clk) begin
      gp_rd_d_o <= in_range ? gp_up_i[gp_idx] : 32'h0;
   end

endmodule

// ==== hw/dma_monitor.sv ====
/*
 * DMA completion and performance monitor
 *  - Three-stage completion size check
 *  - Sticky memory-read done flag
 *  - Write and read performance counters
 */
`timescale 1ns/100ps

module dma_monitor (
   input  logic        clk,
   input  logic        init_rst_i,
   input  logic        mwr_start_i,
   input  logic        mrd_start_i,
   input  logic        mwr_done_i,
   input  logic [15:0] mrd_desc_len_i,
   input  logic [15:0] mrd_count_i,
   input  logic [31:0] cpld_data_size_i,
   output logic        mrd_done_o,
   output logic [31:0] mwr_perf_o,
   output logic [31:0] mrd_perf_o
);

   logic [31:0]                         size_prod;
   logic [bmd_csr_pkg::CPLD_SIZE_W-1:0] expect_size_q;
   logic [bmd_csr_pkg::CPLD_SIZE_W-1:0] cpld_size_q;
   logic                                size_match_q;
   logic [1:0]                          eng_busy;   // Write engine in bit 0
   logic [1:0][31:0]                    perf_q;

   // ----------------------------------------
   // Completion size check
   // ----------------------------------------
   assign size_prod = mrd_desc_len_i * mrd_count_i;

   always_ff @(posedge clk) begin
      expect_size_q <= size_prod[bmd_csr_pkg::CPLD_SIZE_W-1:0];         // Stage 1
      cpld_size_q   <= cpld_data_size_i[bmd_csr_pkg::CPLD_SIZE_W-1:0];
   end

   always_ff @(posedge clk) begin
      if (init_rst_i) begin
         size_match_q <= 1'b0;
         mrd_done_o   <= 1'b0;
      end else begin
         size_match_q <= (expect_size_q == cpld_size_q);                // Stage 2
         if (mrd_start_i && !mrd_done_o && size_match_q) begin          // Stage 3
            mrd_done_o <= 1'b1;
         end
      end
   end

   // ----------------------------------------
   // Performance counters
   // ----------------------------------------
   assign eng_busy[0] = mwr_start_i & ~mwr_done_i;
   assign eng_busy[1] = mrd_start_i & ~mrd_done_o;

   always_ff @(posedge clk) begin
      for (int i = 0; i < 2; i++) begin
         if (init_rst_i) begin
            perf_q[i] <= '0;
         end else if (eng_busy[i]) begin
            perf_q[i] <= perf_q[i] + 32'd1;
         end
      end
   end

   assign mwr_perf_o = perf_q[0];
   assign mrd_perf_o = perf_q[1];

endmodule

// ==== hw/bmd_csr_top.sv ====
/*
 * Top level of the DMA endpoint CSR block
 *  - Register file with initiator reset
 *  - General-purpose register bank
 *  - Completion check and performance monitor
 */
`timescale 1ns/100ps

module bmd_csr_top (
   input  logic                    clk,
   input  logic                    init_rst_i,
   input  bmd_csr_pkg::csr_addr_t  a_i,
   input  logic                    wr_en_i,
   input  bmd_csr_pkg::csr_word_u  wr_d_i,
   output bmd_csr_pkg::csr_word_u  rd_d_o,
   output logic                    init_rst_o,
   output bmd_csr_pkg::dma_cmd_t   mwr_cmd_o,
   output bmd_csr_pkg::dma_cmd_t   mrd_cmd_o,
   output logic [31:0]             mwr_data_o,
   output logic [31:0]             cpld_data_o,
   input  logic                    mwr_done_i,
   output logic                    mrd_done_o,
   input  logic [31:0]             cpld_data_size_i,
   input  bmd_csr_pkg::gp_bank_t   gp_up_i,
   output bmd_csr_pkg::gp_bank_t   gp_dn_o
);

   logic [31:0] mwr_perf;
   logic [31:0] mrd_perf;
   logic [31:0] gp_rd_d;     // Bank read word, ORed into rd_d_o

   csr_regfile u_regfile (
      .clk              (clk),
      .init_rst_i       (init_rst_i),
      .a_i              (a_i),
      .wr_en_i          (wr_en_i),
      .wr_d_i           (wr_d_i),
      .mwr_done_i       (mwr_done_i),
      .mrd_done_i       (mrd_done_o),
      .mwr_perf_i       (mwr_perf),
      .mrd_perf_i       (mrd_perf),
      .cpld_data_size_i (cpld_data_size_i),
      .gp_rd_d_i        (gp_rd_d),
      .rd_d_o           (rd_d_o),
      .init_rst_o       (init_rst_o),
      .mwr_cmd_o        (mwr_cmd_o),
      .mrd_cmd_o        (mrd_cmd_o),
      .mwr_data_o       (mwr_data_o),
      .cpld_data_o      (cpld_data_o)
   );

   gp_port_bank u_gp_bank (
      .clk        (clk),
      .init_rst_i (init_rst_i),
      .a_i        (a_i),
      .wr_en_i    (wr_en_i),
      .wr_d_i     (wr_d_i),
      .gp_up_i    (gp_up_i),
      .gp_dn_o    (gp_dn_o),
      .gp_rd_d_o  (gp_rd_d)
   );

   // Monitor runs off the combined initiator reset
   dma_monitor u_monitor (
      .clk              (clk),
      .init_rst_i       (init_rst_o),
      .mwr_start_i      (mwr_cmd_o.start),
      .mrd_start_i      (mrd_cmd_o.start),
      .mwr_done_i       (mwr_done_i),
      .mrd_desc_len_i   (mrd_cmd_o.desc.len),
      .mrd_count_i      (mrd_cmd_o.count),
      .cpld_data_size_i (cpld_data_size_i),
      .mrd_done_o       (mrd_done_o),
      .mwr_perf_o       (mwr_perf),
      .mrd_perf_o       (mrd_perf)
   );

endmodule

// ==== testbench/bmd_csr_assertions.sv ====
/*
 * Bound checks of the DMA endpoint CSR block
 *  - Start bits clear one cycle into initiator reset
 *  - Read done rises only while the read engine is started
 *  - Read done holds until initiator reset
 */
`timescale 1ns/100ps

module bmd_csr_assertions (
   input logic                  clk,
   input logic                  init_rst_i,
   input logic                  init_rst_o,
   input bmd_csr_pkg::dma_cmd_t mwr_cmd_o,
   input bmd_csr_pkg::dma_cmd_t mrd_cmd_o,
   input logic                  mrd_done_o
);

   rst_clears_start: assert property (@(posedge clk)
      init_rst_o |=> (!mwr_cmd_o.start && !mrd_cmd_o.start))
      else $error("Start bit still set one cycle after init_rst_o");

   done_needs_start: assert property (@(posedge clk) disable iff (init_rst_i)
      $rose(mrd_done_o) |-> $past(mrd_cmd_o.start))
      else $error("mrd_done_o rose without the read start bit");

   // Sticky until the monitor sees initiator reset
   done_is_sticky: assert property (@(posedge clk)
      (mrd_done_o && !init_rst_o) |=> mrd_done_o)
      else $error("mrd_done_o fell without init_rst_o");

endmodule

bind bmd_csr_top bmd_csr_assertions u_assertions (
   .clk        (clk),
   .init_rst_i (init_rst_i),
   .init_rst_o (init_rst_o),
   .mwr_cmd_o  (mwr_cmd_o),
   .mrd_cmd_o  (mrd_cmd_o),
   .mrd_done_o (mrd_done_o)
);

// ==== testbench/tb_bmd_csr.sv ====
/*
 * Testbench of the DMA endpoint CSR block
 *  - Clock, power-on reset and xorshift stimulus
 *  - Register model with field masks
 *  - Typed compare tasks and the run result
 */
`timescale 1ns/100ps

module tb_bmd_csr;

   logic                   clk = 1'b0;
   logic                   init_rst_i;
   bmd_csr_pkg::csr_addr_t a_i;
   logic                   wr_en_i;
   bmd_csr_pkg::csr_word_u wr_d_i;
   bmd_csr_pkg::csr_word_u rd_d_o;
   logic                   init_rst_o;
   bmd_csr_pkg::dma_cmd_t  mwr_cmd_o;
   bmd_csr_pkg::dma_cmd_t  mrd_cmd_o;
   logic [31:0]            mwr_data_o;
   logic [31:0]            cpld_data_o;
   logic                   mwr_done_i;
   logic                   mrd_done_o;
   logic [31:0]            cpld_data_size_i;
   bmd_csr_pkg::gp_bank_t  gp_up_i;
   bmd_csr_pkg::gp_bank_t  gp_dn_o;

   logic [31:0]            reg_model [0:127];   // Kept fields of each written word
   logic                   sw_model;            // Software initiator reset bit
   logic                   done_model;
   bmd_csr_pkg::gp_bank_t  gp_model;
   logic [31:0]            rng = 32'h58b1fcf1;

   bmd_csr_top u_dut (.*);

   always #2 clk = ~clk;

   function automatic logic [31:0] xorshift32();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   // ----------------------------------------
   // Register model
   // ----------------------------------------
   function automatic bmd_csr_pkg::csr_word_u write_mask(input bmd_csr_pkg::csr_addr_t a);
      bmd_csr_pkg::csr_word_u m;
      m.raw = '0;
      case (a)
         bmd_csr_pkg::REG_DMA_CTRL: begin
            m.ctrl.wr      = '1;
            m.ctrl.wr.rsvd = '0;
            m.ctrl.rd      = m.ctrl.wr;     // Same layout for both engines
         end
         bmd_csr_pkg::REG_MWR_DESC, bmd_csr_pkg::REG_MRD_DESC: begin
            m.desc            = '1;
            m.desc.rsvd       = '0;
            m.desc.zerolen_en = (a == bmd_csr_pkg::REG_MWR_DESC);  // Write engine only
         end
         bmd_csr_pkg::REG_MWR_COUNT, bmd_csr_pkg::REG_MRD_COUNT: m.raw = 32'h0000_ffff;
         bmd_csr_pkg::REG_MWR_ADDR, bmd_csr_pkg::REG_MWR_DATA,
         bmd_csr_pkg::REG_CPLD_DATA, bmd_csr_pkg::REG_MRD_ADDR: m.raw = '1;
         default: ;
      endcase
      return m;
   endfunction

   function automatic bmd_csr_pkg::csr_word_u expect_read(input bmd_csr_pkg::csr_addr_t a);
      bmd_csr_pkg::csr_word_u             w;
      logic [bmd_csr_pkg::CSR_ADDR_W-1:0] off;
      off   = a - bmd_csr_pkg::GP_BASE;
      w.raw = '0;
      if (a == bmd_csr_pkg::REG_ID_CTRL)
         w.raw = {bmd_csr_pkg::FPGA_FAMILY, 4'h0, bmd_csr_pkg::INTERFACE_TYPE,
                  bmd_csr_pkg::VERSION_NUMBER, 7'h00, sw_model};
      else if (a <= bmd_csr_pkg::REG_MRD_COUNT)
         w.raw = reg_model[a];
      else if (a == bmd_csr_pkg::REG_CPLD_SIZE)
         w.raw = cpld_data_size_i;
      else if (off < bmd_csr_pkg::GP_COUNT)
         w.raw = gp_up_i[off[bmd_csr_pkg::GP_IDX_W-1:0]];
      if (a == bmd_csr_pkg::REG_DMA_CTRL) begin
         w.ctrl.wr_done = mwr_done_i;
         w.ctrl.rd_done = done_model;
      end
      return w;                            // Performance counters expected idle
   endfunction

   function automatic bmd_csr_pkg::dma_cmd_t expect_cmd(input logic wr);
      bmd_csr_pkg::csr_word_u     ctl;
      bmd_csr_pkg::dma_eng_bits_t eng;
      bmd_csr_pkg::csr_addr_t     b;
      bmd_csr_pkg::dma_cmd_t      c;
      ctl.raw         = reg_model[bmd_csr_pkg::REG_DMA_CTRL];
      eng             = wr ? ctl.ctrl.wr : ctl.ctrl.rd;
      b               = wr ? bmd_csr_pkg::REG_MWR_ADDR : bmd_csr_pkg::REG_MRD_ADDR;
      c.start         = eng.start;
      c.int_dis       = eng.int_dis;
      c.relaxed_order = eng.relaxed_order;
      c.nosnoop       = eng.nosnoop;
      c.addr          = reg_model[b];
      c.desc          = reg_model[b + 7'd1];     // Descriptor follows the address
      c.count         = reg_model[b + 7'd2][15:0];
      return c;
   endfunction

   // ----------------------------------------
   // Compare tasks
   // ----------------------------------------
   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Verification failed");
      $fatal(1);
   endtask

   task automatic check_word(input string name, input bmd_csr_pkg::csr_word_u got,
                             input bmd_csr_pkg::csr_word_u exp);
      if (got !== exp)
         abort_run($sformatf("Error: %s got %h expected %h", name, got.raw, exp.raw));
   endtask

   task automatic check_cmd(input string name, input bmd_csr_pkg::dma_cmd_t got,
                            input bmd_csr_pkg::dma_cmd_t exp);
      if (got !== exp)
         abort_run($sformatf("Error: %s got %h expected %h", name, got, exp));
   endtask

   task automatic check_gp(input string name, input bmd_csr_pkg::gp_bank_t got,
                           input bmd_csr_pkg::gp_bank_t exp);
      if (got !== exp)
         abort_run($sformatf("Error: %s got %h expected %h", name, got, exp));
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp)
         abort_run($sformatf("Error: %s got %h expected %h", name, got, exp));
   endtask

   task automatic check_outputs();
      check_cmd("mwr_cmd_o", mwr_cmd_o, expect_cmd(1'b1));
      check_cmd("mrd_cmd_o", mrd_cmd_o, expect_cmd(1'b0));
      check_word("mwr_data_o", mwr_data_o, reg_model[bmd_csr_pkg::REG_MWR_DATA]);
      check_word("cpld_data_o", cpld_data_o, reg_model[bmd_csr_pkg::REG_CPLD_DATA]);
      check_gp("gp_dn_o", gp_dn_o, gp_model);
      check_bit("mrd_done_o", mrd_done_o, done_model);
   endtask

   // ----------------------------------------
   // Register port
   // ----------------------------------------
   // All tasks start and end 1 ns after a rising edge
   task automatic write_reg(input bmd_csr_pkg::csr_addr_t a, input logic [31:0] d);
      bmd_csr_pkg::csr_word_u             m;
      logic [bmd_csr_pkg::CSR_ADDR_W-1:0] off;
      a_i        = a;
      wr_d_i.raw = d;
      wr_en_i    = 1'b1;
      @(posedge clk);
      #1;
      wr_en_i      = 1'b0;
      m            = write_mask(a);
      off          = a - bmd_csr_pkg::GP_BASE;
      reg_model[a] = d & m.raw;
      if (a == bmd_csr_pkg::REG_ID_CTRL)
         sw_model = d[0];
      if (off < bmd_csr_pkg::GP_COUNT)
         gp_model[off[bmd_csr_pkg::GP_IDX_W-1:0]] = d;
      if (sw_model) begin                  // Engines held idle
         m.raw                                = reg_model[bmd_csr_pkg::REG_DMA_CTRL];
         m.ctrl.wr.start                      = 1'b0;
         m.ctrl.rd.start                      = 1'b0;
         reg_model[bmd_csr_pkg::REG_DMA_CTRL] = m.raw;
      end
   endtask

   task automatic read_word(input bmd_csr_pkg::csr_addr_t a, output logic [31:0] v);
      a_i = a;
      @(posedge clk);
      #1;
      v = rd_d_o.raw;
   endtask

   task automatic check_read(input bmd_csr_pkg::csr_addr_t a);
      a_i = a;
      @(posedge clk);
      #1;
      check_word($sformatf("rd_d_o (addr %0d)", a), rd_d_o, expect_read(a));
   endtask

   task automatic idle(input int n);
      repeat (n) @(posedge clk);
      #1;
   endtask

   task automatic drive_gp_up();
      for (int i = 0; i < bmd_csr_pkg::GP_COUNT; i++)
         gp_up_i[i[bmd_csr_pkg::GP_IDX_W-1:0]] = xorshift32();
   endtask

   task automatic wait_init_rst(input logic level, input int max_cycles);
      int n;
      n = 0;
      while (init_rst_o !== level) begin
         if (n >= max_cycles)
            abort_run($sformatf("init_rst_o did not reach %0d in time", level));
         @(posedge clk);
         #1;
         n++;
      end
   endtask

   task automatic wait_mrd_done(input int max_cycles);
      int n;
      n = 0;
      while (mrd_done_o !== 1'b1) begin
         if (n >= max_cycles)
            abort_run("mrd_done_o did not rise after the matching completion size");
         @(posedge clk);
         #1;
         n++;
      end
   endtask

   task automatic check_perf(input bmd_csr_pkg::csr_addr_t a, input logic running);
      logic [31:0] p0;
      logic [31:0] p1;
      read_word(a, p0);
      read_word(a, p1);
      if (running && p1 <= p0)
         abort_run($sformatf("Counter at addr %0d did not advance while busy", a));
      if (!running && p1 != p0)
         abort_run($sformatf("Counter at addr %0d kept counting after done", a));
   endtask

   // ----------------------------------------
   // Test sequence
   // ----------------------------------------
   initial begin
      bmd_csr_pkg::csr_addr_t a;
      logic [31:0]            d;
      logic [31:0]            r;
      logic [31:0]            prod;
      init_rst_i       = 1'b1;
      a_i              = '0;
      wr_en_i          = 1'b0;
      wr_d_i           = '0;
      mwr_done_i       = 1'b0;
      cpld_data_size_i = '0;
      gp_up_i          = '0;
      reg_model        = '{default: '0};
      sw_model         = 1'b0;
      done_model       = 1'b0;
      gp_model         = '0;
      repeat (10) @(posedge clk);
      #1;
      init_rst_i = 1'b0;
      wait_init_rst(1'b0, 4);

      // Reset values over the whole address space
      drive_gp_up();
      for (int i = 0; i < 128; i++)
         check_read(bmd_csr_pkg::csr_addr_t'(i));
      check_outputs();

      // Random read-back of registers 1 to 9
      for (int n = 0; n < 80; n++) begin
         a = bmd_csr_pkg::csr_addr_t'(1 + xorshift32() % 9);
         d = xorshift32();
         if (a == bmd_csr_pkg::REG_DMA_CTRL)
            d[16] = 1'b0;                  // Read engine stays idle here
         write_reg(a, d);
         check_outputs();
         check_read(a);
      end

      // General-purpose bank
      for (int n = 0; n < 12; n++) begin
         a = bmd_csr_pkg::GP_BASE + bmd_csr_pkg::csr_addr_t'(n % bmd_csr_pkg::GP_COUNT);
         write_reg(a, xorshift32());
         check_gp("gp_dn_o", gp_dn_o, gp_model);
      end
      drive_gp_up();
      for (int i = 0; i <= bmd_csr_pkg::GP_COUNT; i++)
         check_read(bmd_csr_pkg::csr_addr_t'(bmd_csr_pkg::GP_BASE + i));
      check_read(7'h7f);

      // Completion size check and read counter
      d    = xorshift32();
      r    = xorshift32();
      prod = {16'h0000, d[15:0]} * {16'h0000, d[31:16]};
      cpld_data_size_i = {11'h000, prod[20:0] ^ 21'h000001};   // Never matches
      write_reg(bmd_csr_pkg::REG_MRD_DESC, {r[31:16], d[15:0]});
      write_reg(bmd_csr_pkg::REG_MRD_COUNT, {r[15:0], d[31:16]});
      idle(3);
      write_reg(bmd_csr_pkg::REG_DMA_CTRL, 32'h0001_0000);
      check_outputs();
      for (int n = 0; n < 20; n++) begin
         idle(1);
         check_bit("mrd_done_o", mrd_done_o, 1'b0);
      end
      check_perf(bmd_csr_pkg::REG_MRD_PERF, 1'b1);
      cpld_data_size_i = {11'h000, prod[20:0]};
      wait_mrd_done(3);
      done_model = 1'b1;
      check_read(bmd_csr_pkg::REG_DMA_CTRL);
      check_read(bmd_csr_pkg::REG_CPLD_SIZE);
      check_perf(bmd_csr_pkg::REG_MRD_PERF, 1'b0);

      // Write counter runs up to write done
      write_reg(bmd_csr_pkg::REG_DMA_CTRL, 32'h0001_0001);
      check_perf(bmd_csr_pkg::REG_MWR_PERF, 1'b1);
      mwr_done_i = 1'b1;
      idle(1);
      check_perf(bmd_csr_pkg::REG_MWR_PERF, 1'b0);
      check_read(bmd_csr_pkg::REG_DMA_CTRL);

      // Software initiator reset
      write_reg(bmd_csr_pkg::REG_ID_CTRL, 32'h0000_0001);
      wait_init_rst(1'b1, 3);
      idle(2);
      done_model = 1'b0;
      check_outputs();
      for (int i = 0; i < 12; i++)
         check_read(bmd_csr_pkg::csr_addr_t'(i));
      write_reg(bmd_csr_pkg::REG_ID_CTRL, 32'h0000_0000);
      wait_init_rst(1'b0, 3);
      for (int i = 0; i < 16; i++)
         check_read(bmd_csr_pkg::csr_addr_t'(i));
      check_outputs();

      $display("Verification passed");
      $finish;
   end

endmodule

// ==== bmd_csr.f ====
hw/bmd_csr_pkg.sv
hw/csr_regfile.sv
hw/gp_port_bank.sv
hw/dma_monitor.sv
hw/bmd_csr_top.sv
testbench/bmd_csr_assertions.sv
testbench/tb_bmd_csr.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the CSR block testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
   --top-module tb_bmd_csr -f bmd_csr.f

# The log decides the result, so a failing run must not stop the script here
./obj_dir/Vtb_bmd_csr > sim.log 2>&1 || true
cat sim.log

if grep -q "Verification failed" sim.log; then
   echo "Simulation FAILED"
   exit 1
fi
if ! grep -q "Verification passed" sim.log; then
   echo "Simulation ended without a result"
   exit 1
fi
echo "Simulation PASSED"
